//--- all.f
+incdir+design
design/commit_pkg.sv
design/exception_checker.sv
design/mem_align.sv
design/dmem_wb_master.sv
design/exception_commit.sv
design/commit_stage_top.sv
bench/commit_stage_chk.sv
bench/commit_stage_tb.sv

//--- Makefile
SIM      = verilator
TOP      = commit_stage_tb
FILELIST = all.f
VFLAGS   = --binary --assert --timing -j 0
OBJ      = obj_dir
BIN      = $(OBJ)/V$(TOP)
LOG      = sim.log
SRCS     = $(shell grep -v '^+' $(FILELIST)) design/commit_defs.svh

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ) -f $(FILELIST)

run: $(BIN)
	./$(BIN) +verilator+error+limit+1000 > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^sim passed$$" $(LOG)

clean:
	rm -rf $(OBJ) $(LOG)

//--- bench/commit_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "commit_defs.svh"

module commit_stage_tb;

    typedef struct packed {
        commit_pkg::commit_t [1:0] pair;
        logic                      exc_valid;
        commit_pkg::exception_t    exc;
    } expect_t;

    localparam int NUM_PAIRS = 300;
    localparam int MAX_CYCLES = NUM_PAIRS * 40 + 200;

    logic clk;
    logic reset;
    commit_pkg::exec_data_t [1:0] in_pair;
    logic in_valid;
    logic in_ready;
    commit_pkg::status_t status;
    logic [`COMMIT_NINT-1:0] ext_int;
    commit_pkg::commit_t [1:0] commit_pair;
    logic exc_valid;
    commit_pkg::exception_t exc_data;
    logic cyc;
    logic stb;
    logic we;
    commit_pkg::word_t adr;
    commit_pkg::word_t dat_w;
    logic [3:0] sel;
    commit_pkg::word_t dat_r;
    logic ack;

    logic [31:0] lfsr;
    commit_pkg::word_t mem [0:255];
    commit_pkg::word_t wr_word;
    expect_t exp_q[$];
    expect_t head;
    logic have_head;
    commit_pkg::mem_req_t exp_req;
    logic bus_expected;
    logic [1:0] wait_pick;
    logic [1:0] waited;
    int cycles;
    int accepted;
    logic out_event;
    logic head_ok;
    logic bus_ok;

    commit_stage_top UUT (.*);

    always #2 clk = ~clk;

    // galois lfsr, one step per bit
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic commit_pkg::op_e pick_op(input logic [3:0] v);
        case (v)
            4'd7, 4'd8, 4'd9: return commit_pkg::LOAD;
            4'd10, 4'd11: return commit_pkg::STORE;
            4'd12: return commit_pkg::SYSCALL;
            4'd13: return commit_pkg::BREAK;
            4'd14: return commit_pkg::RESERVED;
            default: return commit_pkg::ALU;
        endcase
    endfunction

    // {trap, code} in cause priority order
    function automatic logic [5:0] cause_of(input commit_pkg::exec_data_t d, input logic ip);
        logic mis;
        logic is_mem;
        mis = (d.mem_size == 2'd1) ? d.result[0] : (d.mem_size != 2'd0) && (d.result[1:0] != 0);
        is_mem = (d.op == commit_pkg::LOAD) || (d.op == commit_pkg::STORE);
        if (ip)
            return {1'b1, `EXC_INT};
        else if (d.op == commit_pkg::RESERVED)
            return {1'b1, `EXC_RI};
        else if (d.op == commit_pkg::SYSCALL)
            return {1'b1, `EXC_SYS};
        else if (d.op == commit_pkg::BREAK)
            return {1'b1, `EXC_BP};
        else if (d.overflow)
            return {1'b1, `EXC_OV};
        else if (is_mem && mis)
            return {1'b1, (d.op == commit_pkg::LOAD) ? `EXC_ADEL : `EXC_ADES};
        return 6'd0;
    endfunction

    function automatic commit_pkg::word_t load_extend(input commit_pkg::exec_data_t d,
                                                      input commit_pkg::word_t w);
        commit_pkg::word_t lane;
        lane = w >> (8 * d.result[1:0]);
        if (d.mem_size == 2'd0)
            return {{24{d.load_signed & lane[7]}}, lane[7:0]};
        else if (d.mem_size == 2'd1)
            return {{16{d.load_signed & lane[15]}}, lane[15:0]};
        return w;
    endfunction

    function automatic commit_pkg::mem_req_t store_req(input commit_pkg::exec_data_t d);
        commit_pkg::mem_req_t r;
        r.we = (d.op == commit_pkg::STORE);
        r.adr = {d.result[31:2], 2'b00};
        r.sel = (d.mem_size == 2'd0) ? 4'b0001 : (d.mem_size == 2'd1) ? 4'b0011 : 4'b1111;
        r.sel = r.sel << d.result[1:0];
        r.wdata = '0;
        for (int b = 0; b < 4; b++)
            if (r.sel[b])
                r.wdata[8*b +: 8] = d.store_data[8*(b - d.result[1:0]) +: 8];
        return r;
    endfunction

    function automatic logic outputs_match(input expect_t e,
                                           input commit_pkg::commit_t [1:0] got,
                                           input logic got_exc,
                                           input commit_pkg::exception_t got_data);
        logic ok;
        ok = (got_exc == e.exc_valid);
        for (int l = 0; l < 2; l++)
        begin
            ok &= got[l].valid == e.pair[l].valid;
            if (e.pair[l].valid)
                ok &= got[l].pc == e.pair[l].pc && got[l].destreg == e.pair[l].destreg
                      && got[l].regwrite == e.pair[l].regwrite
                      && got[l].wdata == e.pair[l].wdata;
        end
        if (e.exc_valid)
        begin
            ok &= got_data.code == e.exc.code && got_data.epc == e.exc.epc;
            if (e.exc.code == `EXC_ADEL || e.exc.code == `EXC_ADES)
                ok &= got_data.badvaddr == e.exc.badvaddr;
        end
        return ok;
    endfunction

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("sim failed");
        $fatal(1, "run stopped");
    endtask

    // expected outputs of the pair being accepted now
    task automatic predict();
        expect_t e;
        logic ip;
        logic [5:0] c1;
        logic [5:0] c0;
        commit_pkg::exec_data_t d;
        ip = (|(ext_int & status.im)) && status.ie && !status.exl;
        c1 = cause_of(in_pair[1], ip);
        c0 = cause_of(in_pair[0], 1'b0);
        e = '0;
        e.exc_valid = c1[5] | c0[5];
        d = c1[5] ? in_pair[1] : in_pair[0];
        e.exc.code = c1[5] ? c1[4:0] : c0[4:0];
        e.exc.epc = d.pc;
        e.exc.badvaddr = d.result;
        for (int l = 0; l < 2; l++)
        begin
            d = in_pair[l];
            e.pair[l].valid = (l == 1) ? !c1[5] : !(c1[5] | c0[5]);
            e.pair[l].pc = d.pc;
            e.pair[l].destreg = d.destreg;
            e.pair[l].regwrite = d.regwrite & e.pair[l].valid;
            e.pair[l].wdata = d.result;
            if (e.pair[l].valid && (d.op == commit_pkg::LOAD || d.op == commit_pkg::STORE))
            begin
                exp_req <= store_req(d);
                bus_expected <= 1'b1;
                wait_pick <= 2'(take_bits(2));
                if (d.op == commit_pkg::LOAD)
                    e.pair[l].wdata = load_extend(d, mem[d.result[9:2]]);
            end
        end
        exp_q.push_back(e);
    endtask

    task automatic make_pair();
        commit_pkg::exec_data_t [1:0] p;
        logic [31:0] irq_bits;
        for (int l = 0; l < 2; l++)
        begin
            p[l].valid = 1'b1;
            p[l].pc = take_bits(30) << 2;
            p[l].op = pick_op(4'(take_bits(4)));
            p[l].destreg = 5'(take_bits(5));
            p[l].regwrite = take_bits(1) && p[l].op != commit_pkg::STORE;
            p[l].mem_size = 2'(take_bits(2));
            if (p[l].mem_size == 2'd3)
                p[l].mem_size = 2'd2;
            p[l].result = take_bits(32);
            if (p[l].op == commit_pkg::LOAD || p[l].op == commit_pkg::STORE)
            begin
                p[l].result = take_bits(10);
                // mostly aligned accesses
                if (take_bits(2) != 0)
                    p[l].result[1:0] = p[l].result[1:0] & ~{p[l].mem_size != 0, 1'b1};
            end
            p[l].store_data = take_bits(32);
            p[l].load_signed = 1'(take_bits(1));
            p[l].overflow = p[l].op == commit_pkg::ALU && take_bits(4) == 0;
        end
        if (p[0].op inside {commit_pkg::LOAD, commit_pkg::STORE}
            && p[1].op inside {commit_pkg::LOAD, commit_pkg::STORE})
            p[0].op = commit_pkg::ALU;
        in_pair <= p;
        status <= 8'(take_bits(8));
        irq_bits = '0;
        if (take_bits(2) == 0)
            irq_bits = take_bits(`COMMIT_NINT);
        ext_int <= irq_bits[`COMMIT_NINT-1:0];
        in_valid <= take_bits(2) != 0;
    endtask

    assign out_event = commit_pair[0].valid | commit_pair[1].valid | exc_valid;
    assign head_ok = have_head && outputs_match(head, commit_pair, exc_valid, exc_data);
    assign bus_ok = bus_expected && adr == exp_req.adr && we == exp_req.we
                    && (!we || (sel == exp_req.sel && dat_w == exp_req.wdata));

    commit_check: assert property (@(posedge clk) disable iff (reset) out_event |-> head_ok)
        else fail_now($sformatf("CHECK FAILED at %0t: commit or exception differs", $time));

    bus_check: assert property (@(posedge clk) disable iff (reset) cyc |-> bus_ok)
        else fail_now($sformatf("CHECK FAILED at %0t: unexpected bus request", $time));

    // one cycle after a plain accept, two after the bus ack
    latency_check: assert property (@(posedge clk) disable iff (reset)
        out_event == (($past(in_valid && in_ready) && !bus_expected) || $past(ack, 2)))
        else fail_now($sformatf("CHECK FAILED at %0t: commit at the wrong cycle", $time));

    initial
    begin
        clk = 1'b0;
        reset = 1'b1;
        in_pair = '0;
        in_valid = 1'b0;
        status = '0;
        ext_int = '0;
        dat_r = '0;
        ack = 1'b0;
        lfsr = 32'd46;
        have_head = 1'b0;
        head = '0;
        exp_req = '0;
        bus_expected = 1'b0;
        wait_pick = '0;
        waited = '0;
        cycles = 0;
        accepted = 0;
        for (int i = 0; i < 256; i++)
            mem[i] = (i * 32'h9e37_79b1) ^ 32'h5a5a_0000;
    end

    // wishbone slave with 0 to 3 wait states
    always @(posedge clk)
    begin
        if (reset || ack)
        begin
            ack <= 1'b0;
            waited <= '0;
        end
        else if (cyc && stb)
        begin
            if (waited != wait_pick)
                waited <= waited + 1'b1;
            else
            begin
                ack <= 1'b1;
                dat_r <= mem[adr[9:2]];
                wr_word = mem[adr[9:2]];
                for (int b = 0; b < 4; b++)
                    if (we && sel[b])
                        wr_word[8*b +: 8] = dat_w[8*b +: 8];
                mem[adr[9:2]] <= wr_word;
            end
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles >= MAX_CYCLES)
            fail_now("timeout: the pairs did not all commit within the cycle limit");
        else if (UUT.u_chk.failures != 0)
            fail_now("a Wishbone protocol assertion in commit_stage_chk failed");
        else
        begin
            if (cycles == 8)
                reset <= 1'b0;
            if (!reset)
            begin
                if (out_event && have_head)
                    void'(exp_q.pop_front());
                if (cyc && ack)
                    bus_expected <= 1'b0;
                if (in_valid && in_ready)
                begin
                    predict();
                    accepted++;
                    if (accepted < NUM_PAIRS)
                        make_pair();
                    else
                        in_valid <= 1'b0;
                end
                else if (!in_valid && accepted < NUM_PAIRS)
                begin
                    make_pair();
                    in_valid <= 1'b1;
                end
            end
            have_head = exp_q.size() != 0;
            if (have_head)
                head = exp_q[0];
            if (accepted == NUM_PAIRS && !have_head && !cyc)
            begin
                if (UUT.u_chk.failures != 0)
                    fail_now("a Wishbone protocol assertion in commit_stage_chk failed");
                else
                begin
                    $display("sim passed");
                    $finish;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- bench/commit_stage_chk.sv
`timescale 1ns/1ps
`default_nettype none

module commit_stage_chk (
    input logic              clk,
    input logic              reset,
    input logic              cyc,
    input logic              stb,
    input logic              we,
    input commit_pkg::word_t adr,
    input commit_pkg::word_t dat_w,
    input logic [3:0]        sel,
    input logic              ack,
    input logic              in_ready,
    input logic              exc_valid
);

    int unsigned failures = 0;

    stb_needs_cyc: assert property (@(posedge clk) disable iff (reset) stb |-> cyc)
        else begin failures++; $error("stb high without cyc"); end

    // request held steady through wait states
    req_stable: assert property (@(posedge clk) disable iff (reset)
        (stb && !ack) |=> (stb && $stable(adr) && $stable(we) && $stable(dat_w) && $stable(sel)))
        else begin failures++; $error("request changed during wait state"); end

    cyc_drops: assert property (@(posedge clk) disable iff (reset) (cyc && ack) |=> !cyc)
        else begin failures++; $error("cyc still high after ack"); end

    stall_on_bus: assert property (@(posedge clk) disable iff (reset) cyc |-> !in_ready)
        else begin failures++; $error("in_ready high during bus cycle"); end

    reset_idle: assert property (@(posedge clk) reset |=> (!cyc && !exc_valid && in_ready))
        else begin failures++; $error("outputs not idle after reset"); end

endmodule

bind commit_stage_top commit_stage_chk u_chk (
    .clk, .reset, .cyc, .stb, .we, .adr, .dat_w, .sel, .ack, .in_ready, .exc_valid
);

`default_nettype wire

//--- design/commit_stage_top.sv
`timescale 1ns/1ps
`default_nettype none
`include "commit_defs.svh"

module commit_stage_top (
    input  logic                          clk,
    input  logic                          reset,
    input  commit_pkg::exec_data_t [1:0]  in_pair,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  commit_pkg::status_t           status,
    input  logic [`COMMIT_NINT-1:0]       ext_int,
    output commit_pkg::commit_t [1:0]     commit_pair,
    output logic                          exc_valid,
    output commit_pkg::exception_t        exc_data,
    output logic                          cyc,
    output logic                          stb,
    output logic                          we,
    output commit_pkg::word_t             adr,
    output commit_pkg::word_t             dat_w,
    output logic [3:0]                    sel,
    input  commit_pkg::word_t             dat_r,
    input  logic                          ack
);

    logic mem_start;
    commit_pkg::mem_req_t mem_req;
    logic busy;
    logic mem_done;
    commit_pkg::word_t mem_rdata;

    exception_commit u_commit (
        .clk, .reset, .in_pair, .in_valid, .in_ready, .status, .ext_int,
        .mem_start, .mem_req, .busy, .mem_done, .rdata(mem_rdata),
        .commit_pair, .exc_valid, .exc_data
    );

    dmem_wb_master u_wb (
        .clk, .reset, .mem_start, .req(mem_req), .busy, .mem_done, .rdata(mem_rdata),
        .cyc, .stb, .we, .adr, .dat_w, .sel, .dat_r, .ack
    );

endmodule

`default_nettype wire

//--- design/exception_commit.sv
`timescale 1ns/1ps
`default_nettype none
`include "commit_defs.svh"

module exception_commit (
    input  logic                          clk,
    input  logic                          reset,
    input  commit_pkg::exec_data_t [1:0]  in_pair,
    input  logic                          in_valid,
    output logic                          in_ready,
    input  commit_pkg::status_t           status,
    input  logic [`COMMIT_NINT-1:0]       ext_int,
    output logic                          mem_start,
    output commit_pkg::mem_req_t          mem_req,
    input  logic                          busy,
    input  logic                          mem_done,
    input  commit_pkg::word_t             rdata,
    output commit_pkg::commit_t [1:0]     commit_pair,
    output logic                          exc_valid,
    output commit_pkg::exception_t        exc_data
);

    commit_pkg::commit_t [1:0] lane_out;
    commit_pkg::exception_t [1:0] lane_exc;
    logic [1:0] lane_exc_valid;
    logic [1:0] lane_mem_ok;
    commit_pkg::exception_t pick_exc;
    logic accept;
    logic has_mem;
    logic pending;
    commit_pkg::exec_data_t mem_src;
    commit_pkg::exec_data_t align_in;
    commit_pkg::word_t load_value;
    commit_pkg::commit_t [1:0] hold_commit;
    commit_pkg::exec_data_t hold_mem;
    logic hold_lane;
    logic hold_exc_valid;
    commit_pkg::exception_t hold_exc;
    commit_pkg::commit_t [1:0] done_pair;

    // lane 1 is older and never killed
    exception_checker u_chk1 (
        .in(in_pair[1]), .kill(1'b0), .status, .ext_int,
        .out(lane_out[1]), .exc_valid(lane_exc_valid[1]), .exc(lane_exc[1]),
        .mem_ok(lane_mem_ok[1])
    );

    // interrupts are taken on the older lane only
    exception_checker u_chk0 (
        .in(in_pair[0]), .kill(lane_exc_valid[1]), .status, .ext_int('0),
        .out(lane_out[0]), .exc_valid(lane_exc_valid[0]), .exc(lane_exc[0]),
        .mem_ok(lane_mem_ok[0])
    );

    assign pick_exc = lane_exc_valid[1] ? lane_exc[1] : lane_exc[0];

    assign in_ready = ~pending & ~busy;
    assign accept = in_valid & in_ready;
    assign has_mem = |lane_mem_ok;
    assign mem_src = lane_mem_ok[1] ? in_pair[1] : in_pair[0];

    // aligner follows the held access once it is on the bus
    assign align_in = pending ? hold_mem : mem_src;

    mem_align u_align (
        .req_in(align_in), .rdata, .req(mem_req), .load_value
    );

    assign mem_start = accept & has_mem;

    always_ff @(posedge clk)
    begin
        if (accept && has_mem)
        begin
            hold_commit <= lane_out;
            hold_mem <= mem_src;
            hold_lane <= lane_mem_ok[1];
            hold_exc_valid <= |lane_exc_valid;
            hold_exc <= pick_exc;
        end
    end

    always_comb
    begin
        done_pair = hold_commit;
        if (hold_mem.op == commit_pkg::LOAD)
            done_pair[hold_lane].wdata = load_value;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pending <= 1'b0;
            commit_pair <= '0;
            exc_valid <= 1'b0;
            exc_data <= '0;
        end
        else
        begin
            commit_pair[0].valid <= 1'b0;
            commit_pair[1].valid <= 1'b0;
            exc_valid <= 1'b0;
            if (pending && mem_done)
            begin
                pending <= 1'b0;
                commit_pair <= done_pair;
                exc_valid <= hold_exc_valid;
                exc_data <= hold_exc;
            end
            else if (accept && has_mem)
                pending <= 1'b1;
            else if (accept)
            begin
                commit_pair <= lane_out;
                exc_valid <= |lane_exc_valid;
                exc_data <= pick_exc;
            end
        end
    end

endmodule

`default_nettype wire

//--- design/dmem_wb_master.sv
`timescale 1ns/1ps
`default_nettype none

module dmem_wb_master (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 mem_start,
    input  commit_pkg::mem_req_t req,
    output logic                 busy,
    output logic                 mem_done,
    output commit_pkg::word_t    rdata,
    output logic                 cyc,
    output logic                 stb,
    output logic                 we,
    output commit_pkg::word_t    adr,
    output commit_pkg::word_t    dat_w,
    output logic [3:0]           sel,
    input  commit_pkg::word_t    dat_r,
    input  logic                 ack
);

    commit_pkg::bus_state_e state;
    commit_pkg::mem_req_t bus_req;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= commit_pkg::IDLE;
            mem_done <= 1'b0;
        end
        else
        begin
            mem_done <= 1'b0;
            case (state)
                commit_pkg::IDLE:
                    if (mem_start)
                        state <= commit_pkg::WAIT_ACK;
                commit_pkg::WAIT_ACK:
                    if (ack)
                    begin
                        state <= commit_pkg::IDLE;
                        mem_done <= 1'b1;
                    end
                default:
                    state <= commit_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk)
    begin
        if (state == commit_pkg::IDLE && mem_start)
            bus_req <= req;
        if (state == commit_pkg::WAIT_ACK && ack)
            rdata <= dat_r;
    end

    assign busy = (state != commit_pkg::IDLE);

    // held on the bus until the ack edge
    assign cyc = (state == commit_pkg::WAIT_ACK);
    assign stb = (state == commit_pkg::WAIT_ACK);
    assign we = bus_req.we;
    assign adr = bus_req.adr;
    assign dat_w = bus_req.wdata;
    assign sel = bus_req.sel;

endmodule

`default_nettype wire

//--- design/mem_align.sv
`timescale 1ns/1ps
`default_nettype none

module mem_align (
    input  commit_pkg::exec_data_t req_in,
    input  commit_pkg::word_t      rdata,
    output commit_pkg::mem_req_t   req,
    output commit_pkg::word_t      load_value
);

    logic [4:0] shamt;
    commit_pkg::word_t lane_data;

    // byte offset in bits
    assign shamt = {req_in.result[1:0], 3'b000};

    assign req.we = (req_in.op == commit_pkg::STORE);
    assign req.adr = {req_in.result[$bits(commit_pkg::word_t)-1:2], 2'b00};

    // addressed lanes moved down to bit 0
    assign lane_data = rdata >> shamt;

    always_comb
    begin
        case (req_in.mem_size)
            2'd0:
            begin
                req.wdata = commit_pkg::word_t'(req_in.store_data[7:0]) << shamt;
                req.sel = 4'b0001 << req_in.result[1:0];
                load_value = {{24{req_in.load_signed & lane_data[7]}}, lane_data[7:0]};
            end
            2'd1:
            begin
                req.wdata = commit_pkg::word_t'(req_in.store_data[15:0]) << shamt;
                req.sel = 4'b0011 << req_in.result[1:0];
                load_value = {{16{req_in.load_signed & lane_data[15]}}, lane_data[15:0]};
            end
            default:
            begin
                req.wdata = req_in.store_data;
                req.sel = 4'b1111;
                load_value = rdata;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- design/exception_checker.sv
`timescale 1ns/1ps
`default_nettype none
`include "commit_defs.svh"

module exception_checker (
    input  commit_pkg::exec_data_t   in,
    input  logic                     kill,
    input  commit_pkg::status_t      status,
    input  logic [`COMMIT_NINT-1:0]  ext_int,
    output commit_pkg::commit_t      out,
    output logic                     exc_valid,
    output commit_pkg::exception_t   exc,
    output logic                     mem_ok
);

    logic live;
    logic is_mem;
    logic int_pend;
    logic misaligned;

    assign live = in.valid & ~kill;
    assign is_mem = (in.op == commit_pkg::LOAD) || (in.op == commit_pkg::STORE);
    assign int_pend = (|(ext_int & status.im)) & status.ie & ~status.exl;

    always_comb
    begin
        case (in.mem_size)
            2'd0: misaligned = 1'b0;
            2'd1: misaligned = in.result[0];
            default: misaligned = |in.result[1:0];
        endcase
    end

    // highest priority cause wins
    always_comb
    begin
        exc_valid = 1'b1;
        exc.code = `EXC_INT;
        exc.epc = in.pc;
        exc.badvaddr = '0;
        if (int_pend)
            exc.code = `EXC_INT;
        else if (in.op == commit_pkg::RESERVED)
            exc.code = `EXC_RI;
        else if (in.op == commit_pkg::SYSCALL)
            exc.code = `EXC_SYS;
        else if (in.op == commit_pkg::BREAK)
            exc.code = `EXC_BP;
        else if (in.overflow)
            exc.code = `EXC_OV;
        else if (is_mem && misaligned)
        begin
            exc.code = (in.op == commit_pkg::LOAD) ? `EXC_ADEL : `EXC_ADES;
            exc.badvaddr = in.result;
        end
        else
            exc_valid = 1'b0;
        if (!live)
            exc_valid = 1'b0;
    end

    assign out.valid = live & ~exc_valid;
    assign out.pc = in.pc;
    assign out.destreg = in.destreg;
    assign out.regwrite = in.regwrite & live & ~exc_valid;
    assign out.wdata = in.result;

    assign mem_ok = live & ~exc_valid & is_mem;

endmodule

`default_nettype wire

//--- design/commit_pkg.sv
`default_nettype none
`include "commit_defs.svh"

package commit_pkg;

    typedef logic [`COMMIT_XLEN-1:0] word_t;
    typedef logic [`COMMIT_EXC_W-1:0] exc_code_t;
    typedef logic [4:0] reg_idx_t;

    // 0 byte, 1 half, 2 word
    typedef logic [1:0] mem_size_t;

    typedef enum logic [2:0] {
        ALU,
        LOAD,
        STORE,
        SYSCALL,
        BREAK,
        RESERVED
    } op_e;

    typedef struct packed {
        logic      valid;
        word_t     pc;
        op_e       op;
        reg_idx_t  destreg;
        logic      regwrite;
        // alu result or effective address
        word_t     result;
        word_t     store_data;
        mem_size_t mem_size;
        logic      load_signed;
        logic      overflow;
    } exec_data_t;

    typedef struct packed {
        logic     valid;
        word_t    pc;
        reg_idx_t destreg;
        logic     regwrite;
        word_t    wdata;
    } commit_t;

    typedef struct packed {
        exc_code_t code;
        word_t     epc;
        word_t     badvaddr;
    } exception_t;

    typedef struct packed {
        logic                   ie;
        logic                   exl;
        logic [`COMMIT_NINT-1:0] im;
    } status_t;

    typedef enum logic {
        IDLE,
        WAIT_ACK
    } bus_state_e;

    typedef struct packed {
        logic       we;
        word_t      adr;
        word_t      wdata;
        logic [3:0] sel;
    } mem_req_t;

endpackage

`default_nettype wire

//--- design/commit_defs.svh
`ifndef COMMIT_DEFS_SVH
`define COMMIT_DEFS_SVH

// datapath and cause field widths
`define COMMIT_XLEN  32
`define COMMIT_EXC_W 5

// external interrupt lines, one im bit each
`define COMMIT_NINT  6

// cause register exception codes
`define EXC_INT  5'd0
`define EXC_ADEL 5'd4
`define EXC_ADES 5'd5
`define EXC_SYS  5'd8
`define EXC_BP   5'd9
`define EXC_RI   5'd10
`define EXC_OV   5'd12

`endif
